// File: bench/mem_ep_assertions.sv
`timescale 1ns/1ps

module mem_ep_assertions
  import mem_ep_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input mem_hdr_s rev_hdr_o,
  input fill_t    rev_data_o,
  input logic     rev_v_o,
  input logic     rev_ready_and_i
);

  logic [2:0] left_r;
  logic [2:0] msg_beats;
  mem_hdr_s   hdr_r;

  // Beats in the reverse message that starts now
  always_comb begin
    if (rev_hdr_o.op == e_mem_wr) begin
      msg_beats = 3'd1;
    end else begin
      case (rev_hdr_o.size)
        e_size_16: msg_beats = 3'd2;
        e_size_32: msg_beats = 3'd4;
        default:   msg_beats = 3'd1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      left_r <= '0;
    end else if (rev_v_o && rev_ready_and_i) begin
      if (left_r == '0) begin
        left_r <= msg_beats - 3'd1;
        hdr_r  <= rev_hdr_o;
      end else begin
        left_r <= left_r - 3'd1;
      end
    end
  end

  a_rev_idle_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !rev_v_o)
    else $error("rev_v_o high during reset");

  a_rev_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_v_o && !rev_ready_and_i |=> rev_v_o && $stable(rev_hdr_o) && $stable(rev_data_o))
    else $error("reverse beat changed before it was accepted");

  a_rev_hdr_const: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rev_v_o && (left_r != '0) |-> rev_hdr_o == hdr_r)
    else $error("reverse header changed inside a message");

endmodule

bind mem_ep_top mem_ep_assertions u_mem_ep_assertions (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .rev_hdr_o      (rev_hdr_o),
  .rev_data_o     (rev_data_o),
  .rev_v_o        (rev_v_o),
  .rev_ready_and_i(rev_ready_and_i)
);

// File: bench/mem_ep_checker.sv
`timescale 1ns/1ps
`include "mem_ep_params.svh"

module mem_ep_checker
  import mem_ep_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input mem_hdr_s fwd_hdr_i,
  input fill_t    fwd_data_i,
  input logic     fwd_v_i,
  input logic     fwd_ready_and_i,
  input mem_hdr_s rev_hdr_i,
  input fill_t    rev_data_i,
  input logic     rev_v_i,
  input logic     rev_ready_and_i
);

  typedef struct packed {
    mem_hdr_s hdr;
    fill_t    data;
    logic     last;
  } rsp_s;

  rsp_s  exp_q [$];
  fill_t model [`MEM_EP_SCRATCH_WORDS];
  string test_names [16];
  int    test_errs [16];
  int    error_count = 0;
  int    pass_count  = 0;
  int    fail_count  = 0;
  int    wr_beat     = 0;
  logic  rd_open     = 1'b0;

  function automatic int beats_of(mem_size_e size);
    case (size)
      e_size_16: return 2;
      e_size_32: return 4;
      default:   return 1;
    endcase
  endfunction

  // Word slot of one beat, wrapping modulo the depth
  function automatic int word_of(paddr_t addr, int beat);
    int base;
    base = int'(addr / (`MEM_EP_DATA_W / 8));
    return (base + beat) % `MEM_EP_SCRATCH_WORDS;
  endfunction

  function automatic int pending_beats();
    return exp_q.size();
  endfunction

  task automatic push_rsp(input mem_hdr_s hdr, input fill_t data, input logic last);
    rsp_s r;
    r.hdr  = hdr;
    r.data = data;
    r.last = last;
    exp_q.push_back(r);
  endtask

  task automatic check_beat();
    rsp_s r;
    int   t;
    if (exp_q.size() == 0) begin
      $display("Unexpected reverse beat");
      error_count++;
    end else begin
      r = exp_q.pop_front();
      t = int'(r.hdr.tag);
      if (rev_hdr_i !== r.hdr) begin
        $display("Mismatch %s expected %h actual %h", test_names[t], r.hdr, rev_hdr_i);
        test_errs[t]++;
        error_count++;
      end
      if (rev_data_i !== r.data) begin
        $display("Mismatch %s expected %h actual %h", test_names[t], r.data, rev_data_i);
        test_errs[t]++;
        error_count++;
      end
      if (r.last) begin
        if (test_errs[t] == 0) begin
          $display("Test %s passed", test_names[t]);
          pass_count++;
        end else begin
          $display("Test %s failed", test_names[t]);
          fail_count++;
        end
      end
    end
  endtask

  task automatic final_report();
    rsp_s r;
    while (exp_q.size() != 0) begin
      r = exp_q.pop_front();
      if (r.last) begin
        $display("No response for %s", test_names[int'(r.hdr.tag)]);
        fail_count++;
        error_count++;
      end
    end
    $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, error_count);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (rev_v_i && rev_ready_and_i) begin
        check_beat();
      end
      if (fwd_v_i && fwd_hdr_i.op == e_mem_rd) begin
        // Read beats can return before the read header is consumed
        if (!rd_open) begin
          for (int b = 0; b < beats_of(fwd_hdr_i.size); b++) begin
            push_rsp(fwd_hdr_i,
                     (fwd_hdr_i.addr < paddr_t'(`MEM_EP_SCRATCH_LIMIT)) ?
                       model[word_of(fwd_hdr_i.addr, b)] : '0,
                     b == beats_of(fwd_hdr_i.size) - 1);
          end
        end
        rd_open = !fwd_ready_and_i;
      end else if (fwd_v_i && fwd_ready_and_i) begin
        if (fwd_hdr_i.addr < paddr_t'(`MEM_EP_SCRATCH_LIMIT)) begin
          model[word_of(fwd_hdr_i.addr, wr_beat)] = fwd_data_i;
        end
        // Write ack is one header beat with zero data
        if (wr_beat == beats_of(fwd_hdr_i.size) - 1) begin
          push_rsp(fwd_hdr_i, '0, 1'b1);
          wr_beat = 0;
        end else begin
          wr_beat++;
        end
      end
    end
  end

endmodule

// File: bench/mem_ep_tb.sv
`timescale 1ns/1ps

module mem_ep_tb
  import mem_ep_pkg::*;
;

  localparam int CLK_HALF        = 20;
  localparam int NUM_ENTRIES     = 16;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 4 * 20;
  localparam int DRAIN_CYCLES    = 400;

  typedef struct {
    string     name;
    mem_op_e   op;
    paddr_t    addr;
    mem_size_e size;
    logic [7:0] seed;
    logic      bp;
  } entry_t;

  logic     clk_i;
  logic     rst_n_i;
  mem_hdr_s fwd_hdr_i;
  fill_t    fwd_data_i;
  logic     fwd_v_i;
  logic     fwd_ready_and_o;
  mem_hdr_s rev_hdr_o;
  fill_t    rev_data_o;
  logic     rev_v_o;
  logic     rev_ready_and_i;

  entry_t      entries [NUM_ENTRIES];
  logic        bp_active;
  integer      seed;
  logic [31:0] rand_word;
  int          drain_cnt;

  mem_ep_top u_mem_ep_top (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fwd_hdr_i      (fwd_hdr_i),
    .fwd_data_i     (fwd_data_i),
    .fwd_v_i        (fwd_v_i),
    .fwd_ready_and_o(fwd_ready_and_o),
    .rev_hdr_o      (rev_hdr_o),
    .rev_data_o     (rev_data_o),
    .rev_v_o        (rev_v_o),
    .rev_ready_and_i(rev_ready_and_i)
  );

  mem_ep_checker u_checker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fwd_hdr_i      (fwd_hdr_i),
    .fwd_data_i     (fwd_data_i),
    .fwd_v_i        (fwd_v_i),
    .fwd_ready_and_i(fwd_ready_and_o),
    .rev_hdr_i      (rev_hdr_o),
    .rev_data_i     (rev_data_o),
    .rev_v_i        (rev_v_o),
    .rev_ready_and_i(rev_ready_and_i)
  );

  always #CLK_HALF clk_i = ~clk_i;

  // Reverse back-pressure, random only in marked entries
  always @(negedge clk_i) begin
    if (bp_active) begin
      rand_word = $random(seed);
      rev_ready_and_i <= rand_word[0];
    end else begin
      rev_ready_and_i <= 1'b1;
    end
  end

  task automatic set_entry(input int idx, input string name, input mem_op_e op,
                           input paddr_t addr, input mem_size_e size,
                           input logic [7:0] dseed, input logic bp);
    entries[idx].name = name;
    entries[idx].op   = op;
    entries[idx].addr = addr;
    entries[idx].size = size;
    entries[idx].seed = dseed;
    entries[idx].bp   = bp;
  endtask

  task automatic fill_table();
    set_entry(0,  "wr_scr_1",    e_mem_wr, 32'h0000, e_size_8,  8'h11, 1'b0);
    set_entry(1,  "rd_scr_1",    e_mem_rd, 32'h0000, e_size_8,  8'h00, 1'b0);
    set_entry(2,  "wr_scr_4",    e_mem_wr, 32'h0020, e_size_32, 8'h22, 1'b0);
    set_entry(3,  "rd_scr_4",    e_mem_rd, 32'h0020, e_size_32, 8'h00, 1'b0);
    set_entry(4,  "rd_scr_2",    e_mem_rd, 32'h0028, e_size_16, 8'h00, 1'b0);
    set_entry(5,  "wr_lb_4",     e_mem_wr, 32'h0100, e_size_32, 8'h33, 1'b0);
    set_entry(6,  "rd_lb_4",     e_mem_rd, 32'h0200, e_size_32, 8'h00, 1'b0);
    set_entry(7,  "rd_lb_1",     e_mem_rd, 32'h0080, e_size_8,  8'h00, 1'b0);
    set_entry(8,  "wr_scr_2",    e_mem_wr, 32'h0040, e_size_16, 8'h44, 1'b0);
    set_entry(9,  "rd_lb_alt",   e_mem_rd, 32'h0180, e_size_16, 8'h00, 1'b0);
    set_entry(10, "rd_scr_alt",  e_mem_rd, 32'h0040, e_size_16, 8'h00, 1'b1);
    set_entry(11, "wr_lb_bp",    e_mem_wr, 32'h1000, e_size_16, 8'h55, 1'b1);
    // Beats 2 and 3 wrap onto words 0 and 1
    set_entry(12, "wr_scr_wrap", e_mem_wr, 32'h0070, e_size_32, 8'h66, 1'b1);
    set_entry(13, "rd_scr_last", e_mem_rd, 32'h0000, e_size_16, 8'h00, 1'b1);
    set_entry(14, "rd_scr_bp",   e_mem_rd, 32'h0030, e_size_32, 8'h00, 1'b1);
    set_entry(15, "rd_scr_w9",   e_mem_rd, 32'h0048, e_size_8,  8'h00, 1'b1);
  endtask

  function automatic int size_beats(mem_size_e size);
    case (size)
      e_size_16: return 2;
      e_size_32: return 4;
      default:   return 1;
    endcase
  endfunction

  function automatic fill_t beat_data(logic [7:0] dseed, int beat);
    logic [31:0] lo;
    lo = {dseed, 8'h00, 8'hA5, 8'(beat)};
    return {~lo, lo};
  endfunction

  //////////////////////////////////////////////////
  // Driver
  //////////////////////////////////////////////////

  // One beat per loop; ready is sampled just before the rising edge
  task automatic send_msg(input int idx);
    int   n;
    logic acc;
    n = (entries[idx].op == e_mem_rd) ? 1 : size_beats(entries[idx].size);
    bp_active = entries[idx].bp;
    for (int b = 0; b < n; b++) begin
      @(negedge clk_i);
      fwd_hdr_i.op   = entries[idx].op;
      fwd_hdr_i.addr = entries[idx].addr;
      fwd_hdr_i.size = entries[idx].size;
      fwd_hdr_i.tag  = idx[3:0];
      fwd_data_i     = (entries[idx].op == e_mem_wr) ? beat_data(entries[idx].seed, b) : '0;
      fwd_v_i        = 1'b1;
      acc = 1'b0;
      while (!acc) begin
        #(CLK_HALF - 1);
        acc = fwd_ready_and_o;
        @(posedge clk_i);
        if (!acc) begin
          @(negedge clk_i);
        end
      end
    end
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    fwd_hdr_i       = '0;
    fwd_data_i      = '0;
    fwd_v_i         = 1'b0;
    rev_ready_and_i = 1'b1;
    bp_active       = 1'b0;
    seed            = 10;
    fill_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      u_checker.test_names[i] = entries[i].name;
      send_msg(i);
    end
    @(negedge clk_i);
    fwd_v_i = 1'b0;

    // Let outstanding responses drain
    drain_cnt = 0;
    while (u_checker.pending_beats() != 0 && drain_cnt < DRAIN_CYCLES) begin
      @(posedge clk_i);
      drain_cnt++;
    end
    bp_active = 1'b0;
    repeat (4) @(posedge clk_i);
    u_checker.final_report();

    if (u_checker.error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: DUT did not finish");
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: common/mem_ep_params.svh
`ifndef MEM_EP_PARAMS_SVH
`define MEM_EP_PARAMS_SVH

// Data beat and address widths
`define MEM_EP_DATA_W 64
`define MEM_EP_ADDR_W 32

// Longest message in beats
`define MEM_EP_MAX_BEATS 4

//////////////////////////////////////////////////
// Scratch window
//////////////////////////////////////////////////
`define MEM_EP_SCRATCH_WORDS 16
// First byte address outside the window
`define MEM_EP_SCRATCH_LIMIT 128

`endif

// File: common/mem_ep_pkg.sv
`include "mem_ep_params.svh"

package mem_ep_pkg;

  typedef logic [`MEM_EP_ADDR_W-1:0]            paddr_t;
  typedef logic [`MEM_EP_DATA_W-1:0]            fill_t;
  typedef logic [$clog2(`MEM_EP_MAX_BEATS)-1:0] beat_idx_t;
  typedef logic [3:0]                           msg_tag_t;

  typedef enum logic [1:0] {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } mem_op_e;

  // Size in units of one data beat
  typedef enum logic [1:0] {
    e_size_8  = 2'b00,
    e_size_16 = 2'b01,
    e_size_32 = 2'b10
  } mem_size_e;

  // Same layout for forward and reverse messages
  typedef struct packed {
    mem_op_e   op;
    paddr_t    addr;
    mem_size_e size;
    msg_tag_t  tag;
  } mem_hdr_s;

  typedef enum logic [1:0] {
    e_route_idle    = 2'b00,
    e_route_scratch = 2'b01,
    e_route_loop    = 2'b10
  } route_e;

  // Index of the final beat for a given size
  function automatic beat_idx_t size_last_beat(mem_size_e size);
    beat_idx_t last;
    case (size)
      e_size_16: last = beat_idx_t'(1);
      e_size_32: last = beat_idx_t'(3);
      default:   last = beat_idx_t'(0);
    endcase
    return last;
  endfunction

endpackage

// File: design/mem_ep_top.sv
`timescale 1ns/1ps

module mem_ep_top
  import mem_ep_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  mem_hdr_s fwd_hdr_i,
  input  fill_t    fwd_data_i,
  input  logic     fwd_v_i,
  output logic     fwd_ready_and_o,

  output mem_hdr_s rev_hdr_o,
  output fill_t    rev_data_o,
  output logic     rev_v_o,
  input  logic     rev_ready_and_i
);

  mem_hdr_s scr_fwd_hdr;
  fill_t    scr_fwd_data;
  logic     scr_fwd_v;
  logic     scr_fwd_ready_and;
  mem_hdr_s scr_rev_hdr;
  fill_t    scr_rev_data;
  logic     scr_rev_v;
  logic     scr_rev_ready_and;

  mem_hdr_s lb_fwd_hdr;
  fill_t    lb_fwd_data;
  logic     lb_fwd_v;
  logic     lb_fwd_ready_and;
  mem_hdr_s lb_rev_hdr;
  fill_t    lb_rev_data;
  logic     lb_rev_v;
  logic     lb_rev_ready_and;

  mem_fwd_router u_router (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .fwd_hdr_i          (fwd_hdr_i),
    .fwd_data_i         (fwd_data_i),
    .fwd_v_i            (fwd_v_i),
    .fwd_ready_and_o    (fwd_ready_and_o),
    .rev_hdr_o          (rev_hdr_o),
    .rev_data_o         (rev_data_o),
    .rev_v_o            (rev_v_o),
    .rev_ready_and_i    (rev_ready_and_i),
    .scr_fwd_hdr_o      (scr_fwd_hdr),
    .scr_fwd_data_o     (scr_fwd_data),
    .scr_fwd_v_o        (scr_fwd_v),
    .scr_fwd_ready_and_i(scr_fwd_ready_and),
    .scr_rev_hdr_i      (scr_rev_hdr),
    .scr_rev_data_i     (scr_rev_data),
    .scr_rev_v_i        (scr_rev_v),
    .scr_rev_ready_and_o(scr_rev_ready_and),
    .lb_fwd_hdr_o       (lb_fwd_hdr),
    .lb_fwd_data_o      (lb_fwd_data),
    .lb_fwd_v_o         (lb_fwd_v),
    .lb_fwd_ready_and_i (lb_fwd_ready_and),
    .lb_rev_hdr_i       (lb_rev_hdr),
    .lb_rev_data_i      (lb_rev_data),
    .lb_rev_v_i         (lb_rev_v),
    .lb_rev_ready_and_o (lb_rev_ready_and)
  );

  // Addresses inside the scratch window
  mem_scratchpad u_scratchpad (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fwd_hdr_i      (scr_fwd_hdr),
    .fwd_data_i     (scr_fwd_data),
    .fwd_v_i        (scr_fwd_v),
    .fwd_ready_and_o(scr_fwd_ready_and),
    .rev_hdr_o      (scr_rev_hdr),
    .rev_data_o     (scr_rev_data),
    .rev_v_o        (scr_rev_v),
    .rev_ready_and_i(scr_rev_ready_and)
  );

  // Everything else
  mem_loopback u_loopback (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fwd_hdr_i      (lb_fwd_hdr),
    .fwd_data_i     (lb_fwd_data),
    .fwd_v_i        (lb_fwd_v),
    .fwd_ready_and_o(lb_fwd_ready_and),
    .rev_hdr_o      (lb_rev_hdr),
    .rev_data_o     (lb_rev_data),
    .rev_v_o        (lb_rev_v),
    .rev_ready_and_i(lb_rev_ready_and)
  );

endmodule

// File: design/mem_fwd_router.sv
`timescale 1ns/1ps
`include "mem_ep_params.svh"

module mem_fwd_router
  import mem_ep_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Top side
  input  mem_hdr_s fwd_hdr_i,
  input  fill_t    fwd_data_i,
  input  logic     fwd_v_i,
  output logic     fwd_ready_and_o,
  output mem_hdr_s rev_hdr_o,
  output fill_t    rev_data_o,
  output logic     rev_v_o,
  input  logic     rev_ready_and_i,

  // Scratchpad side
  output mem_hdr_s scr_fwd_hdr_o,
  output fill_t    scr_fwd_data_o,
  output logic     scr_fwd_v_o,
  input  logic     scr_fwd_ready_and_i,
  input  mem_hdr_s scr_rev_hdr_i,
  input  fill_t    scr_rev_data_i,
  input  logic     scr_rev_v_i,
  output logic     scr_rev_ready_and_o,

  // Loopback side
  output mem_hdr_s lb_fwd_hdr_o,
  output fill_t    lb_fwd_data_o,
  output logic     lb_fwd_v_o,
  input  logic     lb_fwd_ready_and_i,
  input  mem_hdr_s lb_rev_hdr_i,
  input  fill_t    lb_rev_data_i,
  input  logic     lb_rev_v_i,
  output logic     lb_rev_ready_and_o
);

  // Wide enough for one buffered beat plus a full read
  localparam int OWED_W = 4;

  route_e            state_r;
  route_e            state_n;
  beat_idx_t         fwd_cnt_r;
  logic [OWED_W-1:0] scr_owed_r;
  logic [OWED_W-1:0] lb_owed_r;
  logic [OWED_W-1:0] rsp_beats;
  logic              booked_r;
  logic              in_window;
  logic              dest_scr;
  logic              block;
  logic              fwd_hs;
  logic              fwd_book;
  logic              fwd_last;
  logic              rev_scr;
  logic              scr_rev_hs;
  logic              lb_rev_hs;

  assign in_window = (fwd_hdr_i.addr < paddr_t'(`MEM_EP_SCRATCH_LIMIT));

  // Destination is locked for the rest of a multi-beat message
  always_comb begin
    case (state_r)
      e_route_scratch: dest_scr = 1'b1;
      e_route_loop:    dest_scr = 1'b0;
      default:         dest_scr = in_window;
    endcase
  end

  // Hold a new message while the other side still owes beats
  assign block = (state_r == e_route_idle) &
                 (dest_scr ? (lb_owed_r != '0) : (scr_owed_r != '0));

  //////////////////////////////////////////////////
  // Forward steering
  //////////////////////////////////////////////////
  assign scr_fwd_hdr_o  = fwd_hdr_i;
  assign scr_fwd_data_o = fwd_data_i;
  assign lb_fwd_hdr_o   = fwd_hdr_i;
  assign lb_fwd_data_o  = fwd_data_i;
  assign scr_fwd_v_o    = fwd_v_i & ~block & dest_scr;
  assign lb_fwd_v_o     = fwd_v_i & ~block & ~dest_scr;

  assign fwd_ready_and_o = ~block & (dest_scr ? scr_fwd_ready_and_i : lb_fwd_ready_and_i);
  assign fwd_hs          = fwd_v_i & fwd_ready_and_o;

  // Read beats leave before the read header is consumed,
  // so a message is booked as soon as it is offered
  assign fwd_book = fwd_v_i & ~block & ~booked_r;

  // Reads send only their header forward
  assign fwd_last  = (fwd_hdr_i.op == e_mem_rd) | (fwd_cnt_r == size_last_beat(fwd_hdr_i.size));
  assign rsp_beats = (fwd_hdr_i.op == e_mem_rd) ?
                     OWED_W'(size_last_beat(fwd_hdr_i.size)) + 1'b1 : OWED_W'(1);

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_route_idle: begin
        if (fwd_hs && !fwd_last) begin
          state_n = dest_scr ? e_route_scratch : e_route_loop;
        end
      end
      e_route_scratch, e_route_loop: begin
        if (fwd_hs && fwd_last) begin
          state_n = e_route_idle;
        end
      end
      default: state_n = e_route_idle;
    endcase
  end

  //////////////////////////////////////////////////
  // Reverse merge
  //////////////////////////////////////////////////

  // Only one side can owe beats at a time
  assign rev_scr = (scr_owed_r != '0);

  assign rev_hdr_o  = rev_scr ? scr_rev_hdr_i : lb_rev_hdr_i;
  assign rev_data_o = rev_scr ? scr_rev_data_i : lb_rev_data_i;
  assign rev_v_o    = rev_scr ? scr_rev_v_i : lb_rev_v_i;

  assign scr_rev_ready_and_o = rev_ready_and_i & rev_scr;
  assign lb_rev_ready_and_o  = rev_ready_and_i & ~rev_scr;

  assign scr_rev_hs = scr_rev_v_i & scr_rev_ready_and_o;
  assign lb_rev_hs  = lb_rev_v_i & lb_rev_ready_and_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r    <= e_route_idle;
      fwd_cnt_r  <= '0;
      booked_r   <= 1'b0;
      scr_owed_r <= '0;
      lb_owed_r  <= '0;
    end else begin
      state_r <= state_n;
      if (fwd_hs) begin
        fwd_cnt_r <= fwd_last ? '0 : fwd_cnt_r + 1'b1;
      end
      if (fwd_hs && fwd_last) begin
        booked_r <= 1'b0;
      end else if (fwd_book) begin
        booked_r <= 1'b1;
      end
      // Owed beats are booked once per message, when it is first offered
      scr_owed_r <= scr_owed_r
                    + ((fwd_book && dest_scr) ? rsp_beats : '0)
                    - OWED_W'(scr_rev_hs);
      lb_owed_r  <= lb_owed_r
                    + ((fwd_book && !dest_scr) ? rsp_beats : '0)
                    - OWED_W'(lb_rev_hs);
    end
  end

endmodule

// File: design/mem_loopback.sv
`timescale 1ns/1ps

module mem_loopback
  import mem_ep_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  mem_hdr_s fwd_hdr_i,
  input  fill_t    fwd_data_i,
  input  logic     fwd_v_i,
  output logic     fwd_ready_and_o,

  output mem_hdr_s rev_hdr_o,
  output fill_t    rev_data_o,
  output logic     rev_v_o,
  input  logic     rev_ready_and_i
);

  mem_hdr_s item_hdr;
  logic     item_v;
  logic     item_yumi;
  logic     out_ready;

  // Incoming data and beat address are not needed here
  stream_pump_in u_pump_in (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .msg_hdr_i      (fwd_hdr_i),
    .msg_data_i     (fwd_data_i),
    .msg_v_i        (fwd_v_i),
    .msg_ready_and_o(fwd_ready_and_o),
    .fsm_hdr_o      (item_hdr),
    .fsm_data_o     (),
    .fsm_v_o        (item_v),
    .fsm_yumi_i     (item_yumi),
    .fsm_addr_o     (),
    .fsm_last_o     ()
  );

  // Echo header, zero payload
  stream_pump_out u_pump_out (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fsm_hdr_i      (item_hdr),
    .fsm_data_i     ('0),
    .fsm_v_i        (item_v),
    .fsm_ready_and_o(out_ready),
    .msg_hdr_o      (rev_hdr_o),
    .msg_data_o     (rev_data_o),
    .msg_v_o        (rev_v_o),
    .msg_ready_and_i(rev_ready_and_i)
  );

  assign item_yumi = item_v & out_ready;

endmodule

// File: design/mem_scratchpad.sv
`timescale 1ns/1ps
`include "mem_ep_params.svh"

module mem_scratchpad
  import mem_ep_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  mem_hdr_s fwd_hdr_i,
  input  fill_t    fwd_data_i,
  input  logic     fwd_v_i,
  output logic     fwd_ready_and_o,

  output mem_hdr_s rev_hdr_o,
  output fill_t    rev_data_o,
  output logic     rev_v_o,
  input  logic     rev_ready_and_i
);

  localparam int IDX_W      = $clog2(`MEM_EP_SCRATCH_WORDS);
  localparam int BYTE_SHIFT = $clog2(`MEM_EP_DATA_W / 8);

  mem_hdr_s         item_hdr;
  fill_t            item_data;
  logic             item_v;
  logic             item_yumi;
  paddr_t           item_addr;
  logic             out_ready;
  logic [IDX_W-1:0] word_idx;
  fill_t            rsp_data;

  fill_t mem_r [`MEM_EP_SCRATCH_WORDS];

  stream_pump_in u_pump_in (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .msg_hdr_i      (fwd_hdr_i),
    .msg_data_i     (fwd_data_i),
    .msg_v_i        (fwd_v_i),
    .msg_ready_and_o(fwd_ready_and_o),
    .fsm_hdr_o      (item_hdr),
    .fsm_data_o     (item_data),
    .fsm_v_o        (item_v),
    .fsm_yumi_i     (item_yumi),
    .fsm_addr_o     (item_addr),
    .fsm_last_o     ()
  );

  stream_pump_out u_pump_out (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fsm_hdr_i      (item_hdr),
    .fsm_data_i     (rsp_data),
    .fsm_v_i        (item_v),
    .fsm_ready_and_o(out_ready),
    .msg_hdr_o      (rev_hdr_o),
    .msg_data_o     (rev_data_o),
    .msg_v_o        (rev_v_o),
    .msg_ready_and_i(rev_ready_and_i)
  );

  assign item_yumi = item_v & out_ready;

  //////////////////////////////////////////////////
  // Word array
  //////////////////////////////////////////////////

  // Word index wraps modulo the array depth
  assign word_idx = item_addr[BYTE_SHIFT +: IDX_W];

  // Reads return the stored word, write acks carry zero
  assign rsp_data = (item_hdr.op == e_mem_rd) ? mem_r[word_idx] : '0;

  always_ff @(posedge clk_i) begin
    if (item_yumi && (item_hdr.op == e_mem_wr)) begin
      mem_r[word_idx] <= item_data;
    end
  end

endmodule

// File: mem_ep.f
+incdir+common
common/mem_ep_pkg.sv
stream_pump/beat_counter.sv
stream_pump/stream_pump_in.sv
stream_pump/stream_pump_out.sv
design/mem_loopback.sv
design/mem_scratchpad.sv
design/mem_fwd_router.sv
design/mem_ep_top.sv
bench/mem_ep_assertions.sv
bench/mem_ep_checker.sv
bench/mem_ep_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_ep_tb -f mem_ep.f -o mem_ep_sim
./obj_dir/mem_ep_sim | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
  exit 0
else
  exit 1
fi

// File: stream_pump/beat_counter.sv
`timescale 1ns/1ps
`include "mem_ep_params.svh"

module beat_counter
  import mem_ep_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  mem_size_e size_i,
  input  logic      step_i,
  input  paddr_t    base_addr_i,

  output paddr_t    addr_o,
  output logic      first_o,
  output logic      last_o
);

  // Byte offset between consecutive beats
  localparam int BYTE_SHIFT = $clog2(`MEM_EP_DATA_W / 8);

  beat_idx_t idx_r;
  beat_idx_t last_idx;

  assign last_idx = size_last_beat(size_i);
  assign first_o  = (idx_r == '0);
  assign last_o   = (idx_r == last_idx);
  assign addr_o   = base_addr_i + (paddr_t'(idx_r) << BYTE_SHIFT);

  // Wrap back to zero after the final beat
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      idx_r <= '0;
    end else if (step_i) begin
      idx_r <= last_o ? '0 : idx_r + 1'b1;
    end
  end

endmodule

// File: stream_pump/stream_pump_in.sv
`timescale 1ns/1ps

module stream_pump_in
  import mem_ep_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Message side
  input  mem_hdr_s msg_hdr_i,
  input  fill_t    msg_data_i,
  input  logic     msg_v_i,
  output logic     msg_ready_and_o,

  // FSM side, one item per beat
  output mem_hdr_s fsm_hdr_o,
  output fill_t    fsm_data_o,
  output logic     fsm_v_o,
  input  logic     fsm_yumi_i,
  output paddr_t   fsm_addr_o,
  output logic     fsm_last_o
);

  logic is_wr;
  logic cnt_last;

  assign is_wr = (msg_hdr_i.op == e_mem_wr);

  // Beat index of the current message
  beat_counter u_beat_counter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .size_i     (msg_hdr_i.size),
    .step_i     (fsm_yumi_i),
    .base_addr_i(msg_hdr_i.addr),
    .addr_o     (fsm_addr_o),
    .first_o    (),
    .last_o     (cnt_last)
  );

  //////////////////////////////////////////////////
  // Item generation
  //////////////////////////////////////////////////

  // Items track the input beat directly, no storage
  assign fsm_hdr_o  = msg_hdr_i;
  assign fsm_data_o = msg_data_i;
  assign fsm_v_o    = msg_v_i;
  assign fsm_last_o = cnt_last;

  // A write beat is consumed with each item.
  // A read header stays until its last item goes.
  assign msg_ready_and_o = fsm_yumi_i & (is_wr | cnt_last);

endmodule

// File: stream_pump/stream_pump_out.sv
`timescale 1ns/1ps

module stream_pump_out
  import mem_ep_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // FSM side
  input  mem_hdr_s fsm_hdr_i,
  input  fill_t    fsm_data_i,
  input  logic     fsm_v_i,
  output logic     fsm_ready_and_o,

  // Message side, registered
  output mem_hdr_s msg_hdr_o,
  output fill_t    msg_data_o,
  output logic     msg_v_o,
  input  logic     msg_ready_and_i
);

  logic     msg_v_r;
  mem_hdr_s msg_hdr_r;
  fill_t    msg_data_r;
  logic     accept;
  logic     emit;
  logic     cnt_first;
  logic     cnt_last;

  beat_counter u_beat_counter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .size_i     (fsm_hdr_i.size),
    .step_i     (accept),
    .base_addr_i(fsm_hdr_i.addr),
    .addr_o     (),
    .first_o    (cnt_first),
    .last_o     (cnt_last)
  );

  // Register is free when empty or draining now
  assign fsm_ready_and_o = ~msg_v_r | msg_ready_and_i;
  assign accept          = fsm_v_i & fsm_ready_and_o;

  // Writes answer with one beat, only on the last item
  assign emit = accept & ((fsm_hdr_i.op == e_mem_rd) | cnt_last);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      msg_v_r <= 1'b0;
    end else if (emit) begin
      msg_v_r <= 1'b1;
    end else if (msg_ready_and_i) begin
      msg_v_r <= 1'b0;
    end
  end

  // Header captured once per message keeps it constant across beats
  always_ff @(posedge clk_i) begin
    if (accept && cnt_first) begin
      msg_hdr_r <= fsm_hdr_i;
    end
    if (emit) begin
      msg_data_r <= fsm_data_i;
    end
  end

  assign msg_hdr_o  = msg_hdr_r;
  assign msg_data_o = msg_data_r;
  assign msg_v_o    = msg_v_r;

endmodule
